/* Makefile */
# Verilator build and run of the execution back end testbench

VERILATOR ?= verilator
TOP       ?= exec_back_end_tb
FILELIST  ?= exec_back_end.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/exec_back_end_assertions.sv */
/*
 * Reorder-buffer checks: occupancy bound, no allocation when full,
 * and retirement walking the slots in order
 */
`timescale 1ns/100ps
`include "exec_cfg.svh"

module exec_back_end_assertions (
    input logic                                  clk_i,
    input logic                                  rst_n_i,
    input logic [$clog2(`EXEC_ROB_DEPTH):0]      count_i,
    input logic                                  full_i,
    input logic                                  alloc_i,
    input logic                                  retire_i,
    input exec_rob_pkg::rob_tag_t                head_i
);

    localparam int DEPTH = `EXEC_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    // Slot of the last retirement, valid once anything has retired
    exec_rob_pkg::rob_tag_t last_slot_q;
    logic                   retired_once_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_slot_q    <= '0;
            retired_once_q <= 1'b0;
        end else if (retire_i) begin
            last_slot_q    <= head_i;
            retired_once_q <= 1'b1;
        end
    end

    count_within_depth: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count_i <= CNT_W'(DEPTH))
        else $error("Reorder buffer holds more entries than its depth");

    // The stall keeps decode from allocating into a full buffer
    full_blocks_alloc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        full_i |-> !alloc_i)
        else $error("Allocation while the reorder buffer is full");

    retire_in_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (retire_i && retired_once_q) |-> (head_i == last_slot_q + 1'b1))
        else $error("Retirement skipped or repeated a reorder-buffer slot");

endmodule : exec_back_end_assertions

bind reorder_buffer exec_back_end_assertions u_assertions (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .count_i(count_q), .full_i(full_o),
    .alloc_i(alloc_i), .retire_i(retire), .head_i(head_q)
);

/* bench/exec_back_end_tb.sv */
/*
 * Testbench for the execution back end: LFSR stimulus, architectural
 * register model and in-order writeback checks
 */
`timescale 1ns/100ps
`include "exec_cfg.svh"

module exec_back_end_tb;

    localparam int NUM_ISSUES  = 2000;
    localparam int NUM_REGS    = `EXEC_NUM_REGS;
    localparam int STALL_LIMIT = 200;
    localparam int ISSUE_LIMIT = 20000;
    localparam int DRAIN_LIMIT = 500;
    localparam int QUIET_CYCLES = 8;

    logic                     clk;
    logic                     rst_n;
    logic                     issue_valid;
    exec_isa_pkg::exec_op_t   issue_op;
    exec_isa_pkg::reg_idx_t   issue_dest;
    exec_isa_pkg::reg_idx_t   issue_src [2];
    exec_isa_pkg::data_word_t issue_operand [2];
    logic                     stall;
    logic                     wb_valid;
    exec_isa_pkg::reg_idx_t   wb_dest;
    exec_isa_pkg::data_word_t wb_data;

    // Speculative image follows issue order, retired image follows writeback
    exec_isa_pkg::data_word_t spec_regs [NUM_REGS];
    exec_isa_pkg::data_word_t retired_regs [NUM_REGS];
    exec_isa_pkg::reg_idx_t   exp_dest_q [$];
    exec_isa_pkg::data_word_t exp_data_q [$];

    // Retired value waiting for the register file write at the end of its cycle
    logic                     wb_pending;
    exec_isa_pkg::reg_idx_t   wb_pending_dest;
    exec_isa_pkg::data_word_t wb_pending_data;

    // Instruction currently offered on the issue port
    logic                     have_instr;
    exec_isa_pkg::exec_op_t   cur_op;
    exec_isa_pkg::reg_idx_t   cur_dest;
    exec_isa_pkg::reg_idx_t   cur_src [2];

    logic [31:0] lfsr;
    logic        accept_seen;
    logic        timed_out;
    int          value_errors;
    int          other_errors;
    int          issued;
    int          retired;
    int          stall_cycles;
    int          cycles;

    exec_back_end DUT (
        .clk_i(clk), .rst_n_i(rst_n),
        .issue_valid_i(issue_valid), .issue_op_i(issue_op), .issue_dest_i(issue_dest),
        .issue_src_i(issue_src), .issue_operand_i(issue_operand),
        .stall_o(stall), .wb_valid_o(wb_valid), .wb_dest_o(wb_dest), .wb_data_o(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // Random source
    // ====================

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) return (s >> 1) ^ 32'h8020_0003;
        return s >> 1;
    endfunction

    // One LFSR step per bit handed out
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ====================
    // Model and checks
    // ====================

    // Result of one instruction as the opcode rules define it
    function automatic exec_isa_pkg::data_word_t expected_result(
        input exec_isa_pkg::exec_op_t op,
        input exec_isa_pkg::data_word_t a,
        input exec_isa_pkg::data_word_t b
    );
        logic [63:0] product;
        product = 64'(a) * 64'(b);
        case (op)
            exec_isa_pkg::OP_ADD: return a + b;
            exec_isa_pkg::OP_SUB: return a - b;
            exec_isa_pkg::OP_AND: return a & b;
            exec_isa_pkg::OP_OR:  return a | b;
            exec_isa_pkg::OP_XOR: return a ^ b;
            exec_isa_pkg::OP_SLL: return a << b[4:0];
            exec_isa_pkg::OP_SRL: return a >> b[4:0];
            // Multiply keeps only the low word
            default:              return product[31:0];
        endcase
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Accepted issue moves the speculative image forward
    task automatic record_issue();
        exec_isa_pkg::data_word_t result;
        result = expected_result(cur_op, spec_regs[cur_src[0]], spec_regs[cur_src[1]]);
        spec_regs[cur_dest] = result;
        exp_dest_q.push_back(cur_dest);
        exp_data_q.push_back(result);
        issued++;
        have_instr   = 1'b0;
        stall_cycles = 0;
    endtask

    // Writebacks must come back in issue order with the model's value
    // Every pulse is counted so a duplicate shows up in the final count
    task automatic check_writeback();
        exec_isa_pkg::reg_idx_t   dest;
        exec_isa_pkg::data_word_t data;
        retired++;
        if (exp_dest_q.size() == 0) begin
            other_errors++;
            $display("Writeback at %0t ns with no instruction outstanding", $time);
        end else begin
            dest = exp_dest_q.pop_front();
            data = exp_data_q.pop_front();
            compare_value("writeback dest", 32'(wb_dest), 32'(dest));
            compare_value("writeback data", wb_data, data);
            wb_pending      = 1'b1;
            wb_pending_dest = dest;
            wb_pending_data = data;
        end
    endtask

    // ====================
    // Stimulus
    // ====================

    // Blocks of 100 issues rotate through gapped or back-to-back issue,
    // and through all registers or only four of them for dependent chains
    task automatic new_instruction();
        logic [31:0] bits;
        int          mode;
        mode = (issued / 100) % 4;
        have_instr = 1'b1;
        if (mode == 0 || mode == 2) begin
            take_bits(2, bits);
            have_instr = (bits[1:0] != 2'b00);
        end
        if (have_instr) begin
            take_bits(3, bits);
            cur_op = exec_isa_pkg::exec_op_t'(bits[2:0]);
            for (int k = 0; k < 3; k++) begin
                take_bits(mode >= 2 ? 2 : 5, bits);
                if (k == 0) cur_dest = bits[4:0];
                else        cur_src[k-1] = bits[4:0];
            end
        end
    endtask

    // Operands are read from the retired image, so they may be stale
    task automatic drive_issue();
        issue_valid = have_instr;
        issue_op    = cur_op;
        issue_dest  = cur_dest;
        for (int s = 0; s < 2; s++) begin
            issue_src[s]     = cur_src[s];
            issue_operand[s] = retired_regs[cur_src[s]];
        end
    endtask

    // One clock: account for the edge, drive after it, sample stall mid-cycle
    task automatic run_cycle();
        @(posedge clk);
        // The register file takes a retired value at the end of its writeback cycle
        if (wb_pending) begin
            retired_regs[wb_pending_dest] = wb_pending_data;
            wb_pending = 1'b0;
        end
        if (accept_seen) record_issue();
        #1;
        if (wb_valid) check_writeback();
        if (!have_instr && issued < NUM_ISSUES) new_instruction();
        drive_issue();
        @(negedge clk);
        accept_seen = issue_valid & ~stall;
        if (issue_valid && stall) begin
            stall_cycles++;
            if (stall_cycles >= STALL_LIMIT) begin
                $display("Timeout: issue port stalled for %0d cycles", stall_cycles);
                other_errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        logic [31:0] bits;
        lfsr = 32'hd32c;
        {value_errors, other_errors, issued, retired, stall_cycles} = '0;
        {have_instr, accept_seen, timed_out, wb_pending} = 4'b0000;
        wb_pending_dest = '0;
        wb_pending_data = '0;
        cur_op   = exec_isa_pkg::OP_ADD;
        cur_dest = '0;
        cur_src  = '{default: '0};
        for (int r = 0; r < NUM_REGS; r++) begin
            take_bits(32, bits);
            spec_regs[r]    = bits;
            retired_regs[r] = bits;
        end
        rst_n = 1'b0;
        drive_issue();
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        // Nothing may come out of an empty back end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            compare_value("wb_valid_o after reset", 32'(wb_valid), 32'd0);
            compare_value("stall_o after reset", 32'(stall), 32'd0);
        end

        cycles = 0;
        while (issued < NUM_ISSUES && !timed_out) begin
            run_cycle();
            cycles++;
            if (cycles >= ISSUE_LIMIT && issued < NUM_ISSUES) begin
                $display("Timeout: only %0d of %0d instructions issued", issued, NUM_ISSUES);
                other_errors++;
                timed_out = 1'b1;
            end
        end

        cycles = 0;
        while (exp_dest_q.size() > 0 && !timed_out) begin
            run_cycle();
            cycles++;
            if (cycles >= DRAIN_LIMIT && exp_dest_q.size() > 0) begin
                $display("Timeout: %0d writebacks still missing", exp_dest_q.size());
                other_errors++;
                timed_out = 1'b1;
            end
        end

        // A duplicated retirement would still pulse after the last expected one
        if (!timed_out) begin
            for (int i = 0; i < QUIET_CYCLES; i++) run_cycle();
            compare_value("writeback count", 32'(retired), 32'(issued));
        end

        $display("Summary: %0d value errors, %0d other errors, %0d issued, %0d retired",
                 value_errors, other_errors, issued, retired);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : exec_back_end_tb

/* exec_back_end.f */
+incdir+rtl
rtl/exec_isa_pkg.sv
rtl/exec_rob_pkg.sv
rtl/issue_decode.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/reorder_buffer.sv
rtl/exec_back_end.sv
bench/exec_back_end_assertions.sv
bench/exec_back_end_tb.sv

/* rtl/alu_unit.sv */
/*
 * One-cycle integer ALU with a registered result and tag
 */
`timescale 1ns/100ps

module alu_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  exec_rob_pkg::dispatch_t   dispatch_i,
    output logic                      valid_o,
    output exec_rob_pkg::rob_tag_t    tag_o,
    output exec_isa_pkg::data_word_t  result_o
);

    exec_isa_pkg::data_word_t a;
    exec_isa_pkg::data_word_t b;
    exec_isa_pkg::data_word_t result;

    assign a = dispatch_i.operand[0];
    assign b = dispatch_i.operand[1];

    // Shift amount is the low five bits of the second operand
    always_comb begin
        case (dispatch_i.op)
            exec_isa_pkg::OP_ADD: result = a + b;
            exec_isa_pkg::OP_SUB: result = a - b;
            exec_isa_pkg::OP_AND: result = a & b;
            exec_isa_pkg::OP_OR:  result = a | b;
            exec_isa_pkg::OP_XOR: result = a ^ b;
            exec_isa_pkg::OP_SLL: result = a << b[4:0];
            exec_isa_pkg::OP_SRL: result = a >> b[4:0];
            // Multiplies never reach this unit
            default:              result = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) valid_o <= 1'b0;
        else          valid_o <= valid_i;
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            tag_o    <= dispatch_i.tag;
            result_o <= result;
        end
    end

endmodule : alu_unit

/* rtl/exec_back_end.sv */
/*
 * Out-of-order execution back end: decode, ALU, multiplier and reorder buffer
 */
`timescale 1ns/100ps

module exec_back_end (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      issue_valid_i,
    input  exec_isa_pkg::exec_op_t    issue_op_i,
    input  exec_isa_pkg::reg_idx_t    issue_dest_i,
    input  exec_isa_pkg::reg_idx_t    issue_src_i [2],
    input  exec_isa_pkg::data_word_t  issue_operand_i [2],
    output logic                      stall_o,
    output logic                      wb_valid_o,
    output exec_isa_pkg::reg_idx_t    wb_dest_o,
    output exec_isa_pkg::data_word_t  wb_data_o
);

    // Decode to reorder buffer
    logic                     alloc;
    exec_isa_pkg::reg_idx_t   alloc_dest;
    exec_rob_pkg::rob_tag_t   alloc_tag;
    logic                     rob_full;
    exec_isa_pkg::reg_idx_t   lookup_src [2];
    logic                     lookup_hit [2];
    logic                     lookup_done [2];
    exec_isa_pkg::data_word_t lookup_data [2];

    // Decode to units
    logic                     alu_valid;
    logic                     mul_valid;
    exec_rob_pkg::dispatch_t  dispatch;

    // Completion port 0 is the ALU, port 1 the multiplier
    logic                     cpl_valid [2];
    exec_rob_pkg::rob_tag_t   cpl_tag [2];
    exec_isa_pkg::data_word_t cpl_data [2];

    issue_decode u_decode (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i), .issue_op_i(issue_op_i),
        .issue_dest_i(issue_dest_i), .issue_src_i(issue_src_i),
        .issue_operand_i(issue_operand_i),
        .alloc_tag_i(alloc_tag), .full_i(rob_full),
        .lookup_hit_i(lookup_hit), .lookup_done_i(lookup_done), .lookup_data_i(lookup_data),
        .stall_o(stall_o), .alloc_o(alloc), .alloc_dest_o(alloc_dest),
        .lookup_src_o(lookup_src),
        .alu_valid_o(alu_valid), .mul_valid_o(mul_valid), .dispatch_o(dispatch)
    );

    alu_unit u_alu (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(alu_valid), .dispatch_i(dispatch),
        .valid_o(cpl_valid[0]), .tag_o(cpl_tag[0]), .result_o(cpl_data[0])
    );

    mul_unit u_mul (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(mul_valid), .dispatch_i(dispatch),
        .valid_o(cpl_valid[1]), .tag_o(cpl_tag[1]), .result_o(cpl_data[1])
    );

    reorder_buffer u_rob (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .alloc_i(alloc), .alloc_dest_i(alloc_dest),
        .cpl_valid_i(cpl_valid), .cpl_tag_i(cpl_tag), .cpl_data_i(cpl_data),
        .lookup_src_i(lookup_src),
        .alloc_tag_o(alloc_tag), .full_o(rob_full),
        .lookup_hit_o(lookup_hit), .lookup_done_o(lookup_done), .lookup_data_o(lookup_data),
        .wb_valid_o(wb_valid_o), .wb_dest_o(wb_dest_o), .wb_data_o(wb_data_o)
    );

endmodule : exec_back_end

/* rtl/exec_cfg.svh */
/*
 * Execution back end configuration: data width, register file size,
 * reorder-buffer depth and multiplier latency
 */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// ====================
// Datapath sizes
// ====================

`define EXEC_XLEN        32
`define EXEC_NUM_REGS    32

// Must stay a power of two so the slot index wraps on its own
`define EXEC_ROB_DEPTH   8

// Cycles from the dispatch cycle to a multiplier result
`define EXEC_MUL_LATENCY 3

`endif

/* rtl/exec_isa_pkg.sv */
/*
 * Instruction-level types of the execution back end: data word,
 * register index and opcode
 */
`include "exec_cfg.svh"

package exec_isa_pkg;

    // One operand or one result
    typedef logic [`EXEC_XLEN-1:0] data_word_t;

    // Architectural register index
    typedef logic [$clog2(`EXEC_NUM_REGS)-1:0] reg_idx_t;

    // Opcodes, all but OP_MUL run on the ALU
    // Shifts take their amount from the low 5 bits of operand 1
    // OP_MUL keeps the low word of the product
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } exec_op_t;

endpackage : exec_isa_pkg

/* rtl/exec_rob_pkg.sv */
/*
 * Reorder-buffer types: slot tag, slot record and the record that
 * decode hands to the execution units
 */
`include "exec_cfg.svh"

package exec_rob_pkg;

    // Slot index, also the tag an instruction carries through execution
    typedef logic [$clog2(`EXEC_ROB_DEPTH)-1:0] rob_tag_t;

    // One reorder-buffer slot
    typedef struct packed {
        logic                    busy;
        logic                    done;
        exec_isa_pkg::reg_idx_t  dest;
        exec_isa_pkg::data_word_t result;
    } rob_entry_t;

    // Decoded instruction with operands already forwarded
    typedef struct packed {
        exec_isa_pkg::exec_op_t         op;
        exec_isa_pkg::data_word_t [1:0] operand;
        rob_tag_t                       tag;
    } dispatch_t;

endpackage : exec_rob_pkg

/* rtl/issue_decode.sv */
/*
 * Issue and decode stage: allocates a reorder-buffer tag, forwards
 * completed results, raises the hazard stall and registers the dispatch
 */
`timescale 1ns/100ps

module issue_decode (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          issue_valid_i,
    input  exec_isa_pkg::exec_op_t        issue_op_i,
    input  exec_isa_pkg::reg_idx_t        issue_dest_i,
    input  exec_isa_pkg::reg_idx_t        issue_src_i [2],
    input  exec_isa_pkg::data_word_t      issue_operand_i [2],
    input  exec_rob_pkg::rob_tag_t        alloc_tag_i,
    input  logic                          full_i,
    input  logic                          lookup_hit_i [2],
    input  logic                          lookup_done_i [2],
    input  exec_isa_pkg::data_word_t      lookup_data_i [2],
    output logic                          stall_o,
    output logic                          alloc_o,
    output exec_isa_pkg::reg_idx_t        alloc_dest_o,
    output exec_isa_pkg::reg_idx_t        lookup_src_o [2],
    output logic                          alu_valid_o,
    output logic                          mul_valid_o,
    output exec_rob_pkg::dispatch_t       dispatch_o
);

    // ====================
    // Hazard and forwarding
    // ====================

    logic                     hazard;
    logic                     accept;
    exec_isa_pkg::data_word_t operand [2];

    // The buffer searches both sources every cycle
    assign lookup_src_o[0] = issue_src_i[0];
    assign lookup_src_o[1] = issue_src_i[1];

    // A producer still in flight holds the issue port
    // Only completed slots can forward, execute outputs are not bypassed
    assign hazard = (lookup_hit_i[0] & ~lookup_done_i[0]) |
                    (lookup_hit_i[1] & ~lookup_done_i[1]);

    assign stall_o = full_i | hazard;
    assign accept  = issue_valid_i & ~stall_o;

    // The newest completed copy replaces the register file value
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            operand[s] = (lookup_hit_i[s] & lookup_done_i[s]) ? lookup_data_i[s]
                                                              : issue_operand_i[s];
        end
    end

    // Slot allocation happens on the same edge that accepts the issue
    assign alloc_o      = accept;
    assign alloc_dest_o = issue_dest_i;

    // ====================
    // Dispatch register
    // ====================

    // Unit valids last exactly one cycle and pick the unit by opcode class
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_valid_o <= 1'b0;
            mul_valid_o <= 1'b0;
        end else begin
            alu_valid_o <= accept & (issue_op_i != exec_isa_pkg::OP_MUL);
            mul_valid_o <= accept & (issue_op_i == exec_isa_pkg::OP_MUL);
        end
    end

    // Payload only moves on an accepted issue
    always_ff @(posedge clk_i) begin
        if (accept) begin
            dispatch_o.op         <= issue_op_i;
            dispatch_o.operand[0] <= operand[0];
            dispatch_o.operand[1] <= operand[1];
            dispatch_o.tag        <= alloc_tag_i;
        end
    end

endmodule : issue_decode

/* rtl/mul_unit.sv */
/*
 * Pipelined multiplier, one new item per cycle, result after a fixed latency
 */
`timescale 1ns/100ps
`include "exec_cfg.svh"

module mul_unit (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  exec_rob_pkg::dispatch_t   dispatch_i,
    output logic                      valid_o,
    output exec_rob_pkg::rob_tag_t    tag_o,
    output exec_isa_pkg::data_word_t  result_o
);

    localparam int LAT = `EXEC_MUL_LATENCY;

    // Stage 0 holds the fresh product, the last stage feeds the reorder buffer
    logic                     valid_q [LAT];
    exec_rob_pkg::rob_tag_t   tag_q   [LAT];
    exec_isa_pkg::data_word_t prod_q  [LAT];
    exec_isa_pkg::data_word_t product;

    // Only the low word of the product is kept
    assign product = dispatch_i.operand[0] * dispatch_i.operand[1];

    // Valid bits are the only control state in the delay line
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < LAT; i++) valid_q[i] <= 1'b0;
        end else begin
            valid_q[0] <= valid_i;
            for (int i = 1; i < LAT; i++) valid_q[i] <= valid_q[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        tag_q[0]  <= dispatch_i.tag;
        prod_q[0] <= product;
        for (int i = 1; i < LAT; i++) begin
            tag_q[i]  <= tag_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign valid_o  = valid_q[LAT-1];
    assign tag_o    = tag_q[LAT-1];
    assign result_o = prod_q[LAT-1];

endmodule : mul_unit

/* rtl/reorder_buffer.sv */
/*
 * Circular reorder buffer: slot allocation, two completion ports,
 * source lookup for forwarding and in-order retirement
 */
`timescale 1ns/100ps
`include "exec_cfg.svh"

module reorder_buffer (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      alloc_i,
    input  exec_isa_pkg::reg_idx_t    alloc_dest_i,
    input  logic                      cpl_valid_i [2],
    input  exec_rob_pkg::rob_tag_t    cpl_tag_i [2],
    input  exec_isa_pkg::data_word_t  cpl_data_i [2],
    input  exec_isa_pkg::reg_idx_t    lookup_src_i [2],
    output exec_rob_pkg::rob_tag_t    alloc_tag_o,
    output logic                      full_o,
    output logic                      lookup_hit_o [2],
    output logic                      lookup_done_o [2],
    output exec_isa_pkg::data_word_t  lookup_data_o [2],
    output logic                      wb_valid_o,
    output exec_isa_pkg::reg_idx_t    wb_dest_o,
    output exec_isa_pkg::data_word_t  wb_data_o
);

    localparam int DEPTH = `EXEC_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    exec_rob_pkg::rob_entry_t entry_q [DEPTH];
    exec_rob_pkg::rob_tag_t   head_q;
    exec_rob_pkg::rob_tag_t   tail_q;
    logic [CNT_W-1:0]         count_q;
    logic                     retire;

    // New instructions take the tail slot, its index is their tag
    assign alloc_tag_o = tail_q;
    assign full_o      = (count_q == CNT_W'(DEPTH));

    // The oldest instruction leaves once its result is in
    assign retire = entry_q[head_q].busy & entry_q[head_q].done;

    // ====================
    // Slot state
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < DEPTH; i++) entry_q[i] <= '0;
        end else begin
            if (alloc_i) begin
                entry_q[tail_q].busy <= 1'b1;
                entry_q[tail_q].done <= 1'b0;
                entry_q[tail_q].dest <= alloc_dest_i;
                tail_q               <= tail_q + 1'b1;
            end
            // Both units may finish in the same cycle, always on different slots
            for (int p = 0; p < 2; p++) begin
                if (cpl_valid_i[p]) begin
                    entry_q[cpl_tag_i[p]].done   <= 1'b1;
                    entry_q[cpl_tag_i[p]].result <= cpl_data_i[p];
                end
            end
            if (retire) begin
                entry_q[head_q].busy <= 1'b0;
                head_q               <= head_q + 1'b1;
            end
            // Allocation and retirement in one cycle leave the count alone
            case ({alloc_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ====================
    // Retirement
    // ====================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) wb_valid_o <= 1'b0;
        else          wb_valid_o <= retire;
    end

    always_ff @(posedge clk_i) begin
        if (retire) begin
            wb_dest_o <= entry_q[head_q].dest;
            wb_data_o <= entry_q[head_q].result;
        end
    end

    // ====================
    // Source lookup
    // ====================

    // Busy slots run contiguously from the head, so walking from the head
    // lets the youngest match overwrite older ones.
    // The writeback register is checked first as the oldest copy since the
    // register file only sees that value one cycle later
    always_comb begin
        exec_rob_pkg::rob_tag_t idx;
        idx = head_q;
        for (int s = 0; s < 2; s++) begin
            lookup_hit_o[s]  = wb_valid_o & (wb_dest_o == lookup_src_i[s]);
            lookup_done_o[s] = lookup_hit_o[s];
            lookup_data_o[s] = wb_data_o;
            for (int i = 0; i < DEPTH; i++) begin
                idx = head_q + exec_rob_pkg::rob_tag_t'(i);
                if (entry_q[idx].busy && entry_q[idx].dest == lookup_src_i[s]) begin
                    lookup_hit_o[s]  = 1'b1;
                    lookup_done_o[s] = entry_q[idx].done;
                    lookup_data_o[s] = entry_q[idx].result;
                end
            end
        end
    end

endmodule : reorder_buffer
